// File: hdl/soc_pkg.sv
// SoC package
// address map, widths and bus payloads
`default_nettype none

package soc_pkg;

	// ------------------------------------------------------------
	// widths
	// ------------------------------------------------------------
	localparam int unsigned ADDR_W = 32;
	localparam int unsigned DATA_W = 64;
	localparam int unsigned LED_W  = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;

	// ------------------------------------------------------------
	// queue depths and credits
	// ------------------------------------------------------------
	// request depth is also the requester's initial credit count
	localparam int unsigned REQ_FIFO_DEPTH = 4;
	localparam int unsigned RSP_FIFO_DEPTH = 2;
	localparam int unsigned RSP_CREDIT_MAX = 2;

	// response credit counter
	typedef logic [$clog2(RSP_CREDIT_MAX+1)-1:0] rsp_crd_t;

	// ------------------------------------------------------------
	// address map
	// ------------------------------------------------------------
	localparam addr_t CLINT_BASE   = 32'h0200_0000;
	localparam addr_t CLINT_LEN    = 32'h0000_C000;
	localparam addr_t GPIO_BASE    = 32'h4000_0000;
	localparam addr_t GPIO_LEN     = 32'h0000_1000;

	// offsets inside the timer block
	localparam addr_t MTIMECMP_OFS = 32'h0000_4000;
	localparam addr_t MTIME_OFS    = 32'h0000_BFF8;

	// offsets inside the gpio block
	localparam addr_t LED_OFS      = 32'h0000_0000;
	localparam addr_t DIP_OFS      = 32'h0000_0008;

	// ------------------------------------------------------------
	// payloads
	// ------------------------------------------------------------
	typedef enum logic [1:0] {
		TGT_CLINT,
		TGT_GPIO,
		TGT_NONE
	} target_e;

	typedef struct packed {
		logic  write;
		addr_t addr;
		data_t data;
	} bus_req_t;

	typedef struct packed {
		data_t data;
		logic  err;
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: hdl/credit_fifo.sv
// Credit-backed queue
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter type         payload_t = logic,
	parameter int unsigned DEPTH     = 2
) (
	input  logic                       sys_clk,
	input  logic                       ndmreset_n,
	input  logic                       push_i,
	input  payload_t                   push_data_i,
	input  logic                       pop_i,
	output payload_t                   pop_data_o,
	output logic                       empty_o,
	output logic [$clog2(DEPTH+1)-1:0] count_o
);

	localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	payload_t                   mem [DEPTH];
	logic [PTR_W-1:0]           wr_ptr_q;
	logic [PTR_W-1:0]           rd_ptr_q;
	logic [$clog2(DEPTH+1)-1:0] count_q;

	// pointer advance with wrap at DEPTH
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// storage
	always_ff @(posedge sys_clk) begin
		if (push_i) begin
			mem[wr_ptr_q] <= push_data_i;
		end
	end

	// pointers and occupancy
	// the sender's credits keep a push away from a full queue
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (push_i) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (pop_i) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({push_i, pop_i})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	assign pop_data_o = mem[rd_ptr_q];
	assign empty_o    = (count_q == '0);
	assign count_o    = count_q;

endmodule

`default_nettype wire

// File: hdl/bus_fabric.sv
// Bus fabric
// request queue, address decode and response return
`timescale 1ns/1ps
`default_nettype none

module bus_fabric (
	input  logic           sys_clk,
	input  logic           ndmreset_n,
	input  logic           req_valid_i,
	input  logic           req_write_i,
	input  soc_pkg::addr_t req_addr_i,
	input  soc_pkg::data_t req_wdata_i,
	output logic           req_credit_o,
	input  logic           rsp_credit_i,
	output logic           rsp_valid_o,
	output soc_pkg::data_t rsp_rdata_o,
	output logic           rsp_err_o,
	output logic           clint_valid_o,
	output logic           gpio_valid_o,
	output logic           tgt_write_o,
	output soc_pkg::addr_t tgt_addr_o,
	output soc_pkg::data_t tgt_wdata_o,
	input  soc_pkg::data_t clint_rdata_i,
	input  soc_pkg::data_t gpio_rdata_i
);

	soc_pkg::bus_req_t req_push_data;
	soc_pkg::bus_req_t req_head;
	logic              req_empty;
	logic              req_pop;
	soc_pkg::bus_rsp_t rsp_push_data;
	soc_pkg::bus_rsp_t rsp_head;
	logic              rsp_empty;
	logic              rsp_pop;
	logic [$clog2(soc_pkg::RSP_FIFO_DEPTH+1)-1:0] rsp_count;
	soc_pkg::target_e  tgt_sel;
	soc_pkg::target_e  tgt_q;
	logic              pending_q;
	soc_pkg::rsp_crd_t rsp_crd_q;
	logic              req_credit_q;
	logic              rsp_valid_q;
	soc_pkg::data_t    rsp_rdata_q;
	logic              rsp_err_q;

	// ------------------------------------------------------------
	// request side
	// ------------------------------------------------------------
	assign req_push_data = '{write: req_write_i, addr: req_addr_i, data: req_wdata_i};

	credit_fifo #(
		.payload_t ( soc_pkg::bus_req_t     ),
		.DEPTH     ( soc_pkg::REQ_FIFO_DEPTH )
	) i_req_fifo (
		.sys_clk     ( sys_clk       ),
		.ndmreset_n  ( ndmreset_n    ),
		.push_i      ( req_valid_i   ),
		.push_data_i ( req_push_data ),
		.pop_i       ( req_pop       ),
		.pop_data_o  ( req_head      ),
		.empty_o     ( req_empty     ),
		.count_o     (               )
	);

	// reserve a response slot for the one in the target stage
	assign req_pop = !req_empty && ((rsp_count + pending_q) < soc_pkg::RSP_FIFO_DEPTH);

	// address decode, offset goes to the selected block
	always_comb begin
		tgt_sel    = soc_pkg::TGT_NONE;
		tgt_addr_o = '0;
		if (req_head.addr >= soc_pkg::CLINT_BASE &&
		    req_head.addr < soc_pkg::CLINT_BASE + soc_pkg::CLINT_LEN) begin
			tgt_sel    = soc_pkg::TGT_CLINT;
			tgt_addr_o = req_head.addr - soc_pkg::CLINT_BASE;
		end else if (req_head.addr >= soc_pkg::GPIO_BASE &&
		             req_head.addr < soc_pkg::GPIO_BASE + soc_pkg::GPIO_LEN) begin
			tgt_sel    = soc_pkg::TGT_GPIO;
			tgt_addr_o = req_head.addr - soc_pkg::GPIO_BASE;
		end
	end

	// unmapped accesses strobe nobody
	assign clint_valid_o = req_pop && (tgt_sel == soc_pkg::TGT_CLINT);
	assign gpio_valid_o  = req_pop && (tgt_sel == soc_pkg::TGT_GPIO);
	assign tgt_write_o   = req_head.write;
	assign tgt_wdata_o   = req_head.data;

	// ------------------------------------------------------------
	// target stage
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			pending_q <= 1'b0;
			tgt_q     <= soc_pkg::TGT_NONE;
		end else begin
			pending_q <= req_pop;
			tgt_q     <= tgt_sel;
		end
	end

	always_comb begin
		case (tgt_q)
			soc_pkg::TGT_CLINT: rsp_push_data = '{data: clint_rdata_i, err: 1'b0};
			soc_pkg::TGT_GPIO:  rsp_push_data = '{data: gpio_rdata_i, err: 1'b0};
			default:            rsp_push_data = '{data: '0, err: 1'b1};
		endcase
	end

	// ------------------------------------------------------------
	// response side
	// ------------------------------------------------------------
	credit_fifo #(
		.payload_t ( soc_pkg::bus_rsp_t     ),
		.DEPTH     ( soc_pkg::RSP_FIFO_DEPTH )
	) i_rsp_fifo (
		.sys_clk     ( sys_clk       ),
		.ndmreset_n  ( ndmreset_n    ),
		.push_i      ( pending_q     ),
		.push_data_i ( rsp_push_data ),
		.pop_i       ( rsp_pop       ),
		.pop_data_o  ( rsp_head      ),
		.empty_o     ( rsp_empty     ),
		.count_o     ( rsp_count     )
	);

	assign rsp_pop = !rsp_empty && (rsp_crd_q != '0);

	// credits held for the requester's response buffers
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			rsp_crd_q <= soc_pkg::rsp_crd_t'(soc_pkg::RSP_CREDIT_MAX);
		end else begin
			case ({rsp_pop, rsp_credit_i})
				2'b10:   rsp_crd_q <= rsp_crd_q - 1'b1;
				2'b01:   rsp_crd_q <= rsp_crd_q + 1'b1;
				default: rsp_crd_q <= rsp_crd_q;
			endcase
		end
	end

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			rsp_valid_q  <= 1'b0;
			req_credit_q <= 1'b0;
		end else begin
			rsp_valid_q  <= rsp_pop;
			req_credit_q <= req_pop;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rsp_pop) begin
			rsp_rdata_q <= rsp_head.data;
			rsp_err_q   <= rsp_head.err;
		end
	end

	assign rsp_valid_o  = rsp_valid_q;
	assign rsp_rdata_o  = rsp_rdata_q;
	assign rsp_err_o    = rsp_err_q;
	assign req_credit_o = req_credit_q;

endmodule

`default_nettype wire

// File: hdl/clint_timer.sv
// Core-local timer
`timescale 1ns/1ps
`default_nettype none

module clint_timer (
	input  logic           sys_clk,
	input  logic           ndmreset_n,
	input  logic           valid_i,
	input  logic           write_i,
	input  soc_pkg::addr_t addr_i,
	input  soc_pkg::data_t wdata_i,
	output soc_pkg::data_t rdata_o,
	output logic           timer_irq_o
);

	logic           rtc_q;
	soc_pkg::data_t mtime_q;
	soc_pkg::data_t mtimecmp_q;
	soc_pkg::data_t rd_mux;
	soc_pkg::data_t rdata_q;
	logic           irq_q;
	logic           wr_mtime;
	logic           wr_mtimecmp;

	assign wr_mtime    = valid_i && write_i && (addr_i == soc_pkg::MTIME_OFS);
	assign wr_mtimecmp = valid_i && write_i && (addr_i == soc_pkg::MTIMECMP_OFS);

	// ------------------------------------------------------------
	// real-time tick at half the clock rate
	// ------------------------------------------------------------
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			rtc_q <= 1'b0;
		end else begin
			rtc_q <= ~rtc_q;
		end
	end

	// mtime, a bus write wins over the tick
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			mtime_q <= '0;
		end else if (wr_mtime) begin
			mtime_q <= wdata_i;
		end else if (rtc_q) begin
			mtime_q <= mtime_q + 1'b1;
		end
	end

	// compare value starts at all ones so no irq out of reset
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			mtimecmp_q <= '1;
		end else if (wr_mtimecmp) begin
			mtimecmp_q <= wdata_i;
		end
	end

	// ------------------------------------------------------------
	// read port
	// ------------------------------------------------------------
	always_comb begin
		case (addr_i)
			soc_pkg::MTIME_OFS:    rd_mux = mtime_q;
			soc_pkg::MTIMECMP_OFS: rd_mux = mtimecmp_q;
			default:               rd_mux = '0;
		endcase
	end

	// writes answer with zero
	always_ff @(posedge sys_clk) begin
		if (valid_i) begin
			rdata_q <= write_i ? '0 : rd_mux;
		end
	end

	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			irq_q <= 1'b0;
		end else begin
			irq_q <= (mtime_q >= mtimecmp_q);
		end
	end

	assign rdata_o     = rdata_q;
	assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// File: hdl/gpio_regs.sv
// Board GPIO registers
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
	input  logic                      sys_clk,
	input  logic                      ndmreset_n,
	input  logic                      valid_i,
	input  logic                      write_i,
	input  soc_pkg::addr_t            addr_i,
	input  soc_pkg::data_t            wdata_i,
	output soc_pkg::data_t            rdata_o,
	input  logic [soc_pkg::LED_W-1:0] dip_switches_i,
	output logic [soc_pkg::LED_W-1:0] led_o
);

	logic [soc_pkg::LED_W-1:0] led_q;
	soc_pkg::data_t            rd_mux;
	soc_pkg::data_t            rdata_q;

	// led register, only the low byte is kept
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			led_q <= '0;
		end else if (valid_i && write_i && (addr_i == soc_pkg::LED_OFS)) begin
			led_q <= wdata_i[soc_pkg::LED_W-1:0];
		end
	end

	// switches are sampled by the read itself
	always_comb begin
		case (addr_i)
			soc_pkg::LED_OFS: rd_mux = soc_pkg::data_t'(led_q);
			soc_pkg::DIP_OFS: rd_mux = soc_pkg::data_t'(dip_switches_i);
			default:          rd_mux = '0;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (valid_i) begin
			rdata_q <= write_i ? '0 : rd_mux;
		end
	end

	assign rdata_o = rdata_q;
	assign led_o   = led_q;

endmodule

`default_nettype wire

// File: hdl/soc_top.sv
// SoC top level
// fabric, timer and gpio
`timescale 1ns/1ps
`default_nettype none

module soc_top (
	input  logic                      sys_clk,
	input  logic                      ndmreset_n,
	input  logic                      req_valid_i,
	input  logic                      req_write_i,
	input  soc_pkg::addr_t            req_addr_i,
	input  soc_pkg::data_t            req_wdata_i,
	output logic                      req_credit_o,
	input  logic                      rsp_credit_i,
	output logic                      rsp_valid_o,
	output soc_pkg::data_t            rsp_rdata_o,
	output logic                      rsp_err_o,
	input  logic [soc_pkg::LED_W-1:0] dip_switches_i,
	output logic [soc_pkg::LED_W-1:0] led_o,
	output logic                      timer_irq_o
);

	// target bus
	logic           clint_valid;
	logic           gpio_valid;
	logic           tgt_write;
	soc_pkg::addr_t tgt_addr;
	soc_pkg::data_t tgt_wdata;
	soc_pkg::data_t clint_rdata;
	soc_pkg::data_t gpio_rdata;

	// ------------------------------------------------------------
	// fabric
	// ------------------------------------------------------------
	bus_fabric i_bus_fabric (
		.sys_clk       ( sys_clk      ),
		.ndmreset_n    ( ndmreset_n   ),
		.req_valid_i   ( req_valid_i  ),
		.req_write_i   ( req_write_i  ),
		.req_addr_i    ( req_addr_i   ),
		.req_wdata_i   ( req_wdata_i  ),
		.req_credit_o  ( req_credit_o ),
		.rsp_credit_i  ( rsp_credit_i ),
		.rsp_valid_o   ( rsp_valid_o  ),
		.rsp_rdata_o   ( rsp_rdata_o  ),
		.rsp_err_o     ( rsp_err_o    ),
		.clint_valid_o ( clint_valid  ),
		.gpio_valid_o  ( gpio_valid   ),
		.tgt_write_o   ( tgt_write    ),
		.tgt_addr_o    ( tgt_addr     ),
		.tgt_wdata_o   ( tgt_wdata    ),
		.clint_rdata_i ( clint_rdata  ),
		.gpio_rdata_i  ( gpio_rdata   )
	);

	// ------------------------------------------------------------
	// targets
	// ------------------------------------------------------------
	clint_timer i_clint_timer (
		.sys_clk     ( sys_clk     ),
		.ndmreset_n  ( ndmreset_n  ),
		.valid_i     ( clint_valid ),
		.write_i     ( tgt_write   ),
		.addr_i      ( tgt_addr    ),
		.wdata_i     ( tgt_wdata   ),
		.rdata_o     ( clint_rdata ),
		.timer_irq_o ( timer_irq_o )
	);

	gpio_regs i_gpio_regs (
		.sys_clk        ( sys_clk        ),
		.ndmreset_n     ( ndmreset_n     ),
		.valid_i        ( gpio_valid     ),
		.write_i        ( tgt_write      ),
		.addr_i         ( tgt_addr       ),
		.wdata_i        ( tgt_wdata      ),
		.rdata_o        ( gpio_rdata     ),
		.dip_switches_i ( dip_switches_i ),
		.led_o          ( led_o          )
	);

endmodule

`default_nettype wire

// File: bench/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic sys_clk_o,
	output logic ndmreset_n_o
);

	// 8 ns period
	initial begin
		sys_clk_o = 1'b0;
		forever #4 sys_clk_o = ~sys_clk_o;
	end

	// reset held for four rising edges, released just after the last one
	initial begin
		ndmreset_n_o = 1'b0;
		repeat (4) @(posedge sys_clk_o);
		#1 ndmreset_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: bench/soc_sva.sv
// Bus protocol assertions
`timescale 1ns/1ps
`default_nettype none

module soc_sva (
	input logic                      sys_clk,
	input logic                      ndmreset_n,
	input logic                      req_valid_i,
	input logic                      req_credit_i,
	input logic                      rsp_valid_i,
	input soc_pkg::rsp_crd_t         rsp_crd_i,
	input logic [soc_pkg::LED_W-1:0] led_i,
	input logic                      timer_irq_i
);

	int unsigned acc_cnt_q;
	int unsigned crd_cnt_q;
	int unsigned crd_fail_cnt = 0;
	int unsigned rsp_fail_cnt = 0;
	int unsigned rst_fail_cnt = 0;

	// accepted requests and returned request credits so far
	always_ff @(posedge sys_clk or negedge ndmreset_n) begin
		if (!ndmreset_n) begin
			acc_cnt_q <= 0;
			crd_cnt_q <= 0;
		end else begin
			if (req_valid_i) begin
				acc_cnt_q <= acc_cnt_q + 1;
			end
			if (req_credit_i) begin
				crd_cnt_q <= crd_cnt_q + 1;
			end
		end
	end

	// ------------------------------------------------------------
	// credits
	// ------------------------------------------------------------
	req_credit_bound: assert property (@(posedge sys_clk) disable iff (!ndmreset_n)
		(crd_cnt_q + 32'(req_credit_i)) <= acc_cnt_q)
	else begin
		$error("req_credit_o pulse without a matching accepted request");
		crd_fail_cnt++;
	end

	// valid is registered, so the count that allowed it is one cycle old
	rsp_credit_held: assert property (@(posedge sys_clk) disable iff (!ndmreset_n)
		rsp_valid_i |-> ($past(rsp_crd_i) != '0))
	else begin
		$error("rsp_valid_o raised while the response credit count was zero");
		rsp_fail_cnt++;
	end

	// ------------------------------------------------------------
	// state right after reset
	// ------------------------------------------------------------
	reset_state: assert property (@(posedge sys_clk) $rose(ndmreset_n) |->
		(led_i == '0 && !rsp_valid_i && !req_credit_i && !timer_irq_i))
	else begin
		$error("outputs not at their reset values in the first cycle after reset");
		rst_fail_cnt++;
	end

endmodule

bind soc_top soc_sva i_soc_sva (
	.sys_clk      ( sys_clk                ),
	.ndmreset_n   ( ndmreset_n             ),
	.req_valid_i  ( req_valid_i            ),
	.req_credit_i ( req_credit_o           ),
	.rsp_valid_i  ( rsp_valid_o            ),
	.rsp_crd_i    ( i_bus_fabric.rsp_crd_q ),
	.led_i        ( led_o                  ),
	.timer_irq_i  ( timer_irq_o            )
);

`default_nettype wire

// File: bench/tb_soc.sv
// SoC testbench
// requester model, response checks and timeout
`timescale 1ns/1ps
`default_nettype none

module tb_soc;

	// all tests take well under a thousand cycles
	localparam int unsigned MAX_CYCLES = 4000;

	logic                      sys_clk;
	logic                      ndmreset_n;
	logic                      req_valid    = 1'b0;
	logic                      req_write    = 1'b0;
	soc_pkg::addr_t            req_addr     = '0;
	soc_pkg::data_t            req_wdata    = '0;
	logic                      req_credit;
	logic                      rsp_credit   = 1'b0;
	logic                      rsp_valid;
	soc_pkg::data_t            rsp_rdata;
	logic                      rsp_err;
	logic [soc_pkg::LED_W-1:0] dip_switches = '0;
	logic [soc_pkg::LED_W-1:0] led;
	logic                      timer_irq;

	// requester bookkeeping
	int unsigned               sent_cnt      = 0;
	int unsigned               crd_back_cnt  = 0;
	int unsigned               rsp_cnt       = 0;
	int unsigned               rsp_crd_given = 0;
	int unsigned               cycle_cnt     = 0;
	int unsigned               err_cnt       = 0;
	int unsigned               mon_err_cnt   = 0;
	int unsigned               test_base     = 0;
	int unsigned               tests_ok      = 0;
	int unsigned               tests_bad     = 0;
	bit                        hold_rsp_crd  = 1'b0;
	soc_pkg::data_t            exp_data_q[$];
	bit                        exp_err_q[$];
	bit                        exp_chk_q[$];
	soc_pkg::data_t            last_rdata    = '0;
	logic [soc_pkg::LED_W-1:0] led_val       = '0;
	logic [soc_pkg::LED_W-1:0] dip_val       = '0;
	int unsigned               k_val         = 0;

	tb_clk_gen i_tb_clk_gen (
		.sys_clk_o    ( sys_clk    ),
		.ndmreset_n_o ( ndmreset_n )
	);

	soc_top i_soc_top (
		.sys_clk        ( sys_clk      ),
		.ndmreset_n     ( ndmreset_n   ),
		.req_valid_i    ( req_valid    ),
		.req_write_i    ( req_write    ),
		.req_addr_i     ( req_addr     ),
		.req_wdata_i    ( req_wdata    ),
		.req_credit_o   ( req_credit   ),
		.rsp_credit_i   ( rsp_credit   ),
		.rsp_valid_o    ( rsp_valid    ),
		.rsp_rdata_o    ( rsp_rdata    ),
		.rsp_err_o      ( rsp_err      ),
		.dip_switches_i ( dip_switches ),
		.led_o          ( led          ),
		.timer_irq_o    ( timer_irq    )
	);

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic int unsigned check_value(input string name,
	                                            input soc_pkg::data_t exp_v,
	                                            input soc_pkg::data_t act_v);
		int unsigned bad;
		bad = 0;
		assert (act_v === exp_v) else begin
			$display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp_v, act_v);
			bad = 1;
		end
		return bad;
	endfunction

	// each step ends just after a rising edge
	task automatic wait_cycles(input int unsigned n);
		repeat (n) begin
			@(posedge sys_clk);
			#1;
		end
	endtask

	task automatic send_req(input logic write, input soc_pkg::addr_t addr,
	                        input soc_pkg::data_t wdata, input soc_pkg::data_t exp_data,
	                        input bit exp_err, input bit exp_chk);
		wait_cycles($urandom_range(0, 2));
		while (sent_cnt - crd_back_cnt >= soc_pkg::REQ_FIFO_DEPTH) begin
			wait_cycles(1);
		end
		exp_data_q.push_back(exp_data);
		exp_err_q.push_back(exp_err);
		exp_chk_q.push_back(exp_chk);
		req_valid = 1'b1;
		req_write = write;
		req_addr  = addr;
		req_wdata = wdata;
		sent_cnt++;
		wait_cycles(1);
		req_valid = 1'b0;
	endtask

	task automatic send_mixed_read(input int unsigned kind);
		case (kind)
			0: send_req(1'b0, soc_pkg::GPIO_BASE + soc_pkg::LED_OFS, '0, 64'(led_val), 1'b0, 1'b1);
			1: send_req(1'b0, soc_pkg::GPIO_BASE + soc_pkg::DIP_OFS, '0, 64'(dip_val), 1'b0, 1'b1);
			2: send_req(1'b0, soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, '0, 64'(k_val),
			            1'b0, 1'b1);
			// first address past the gpio block
			default: send_req(1'b0, soc_pkg::GPIO_BASE + soc_pkg::GPIO_LEN, '0, '0, 1'b1, 1'b1);
		endcase
	endtask

	task automatic wait_drain();
		while (exp_data_q.size() > 0) begin
			wait_cycles(1);
		end
	endtask

	task automatic end_test(input string name);
		int unsigned errs;
		errs      = err_cnt + mon_err_cnt - test_base;
		test_base = err_cnt + mon_err_cnt;
		if (errs == 0) begin
			tests_ok++;
			$display("test %s: ok", name);
		end else begin
			tests_bad++;
			$display("test %s: %0d errors", name, errs);
		end
	endtask

	// ------------------------------------------------------------
	// response side of the requester
	// ------------------------------------------------------------
	// responses must match the expected queue in request order
	always @(posedge sys_clk) begin
		if (req_credit) begin
			crd_back_cnt++;
		end
		if (rsp_valid) begin
			rsp_cnt++;
			last_rdata = rsp_rdata;
			assert (exp_data_q.size() > 0) else begin
				$display("unexpected response at %0t with no request outstanding", $time);
				mon_err_cnt++;
			end
			if (exp_data_q.size() > 0) begin
				if (exp_chk_q[0]) begin
					mon_err_cnt += check_value("rsp_rdata_o", exp_data_q[0], rsp_rdata);
				end
				mon_err_cnt += check_value("rsp_err_o", 64'(exp_err_q[0]), 64'(rsp_err));
				void'(exp_data_q.pop_front());
				void'(exp_err_q.pop_front());
				void'(exp_chk_q.pop_front());
			end
		end
	end

	// one buffer freed per response unless held back
	always @(posedge sys_clk) begin
		#1;
		if (!hold_rsp_crd && rsp_crd_given < rsp_cnt) begin
			rsp_credit = 1'b1;
			rsp_crd_given++;
		end else begin
			rsp_credit = 1'b0;
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("** FAIL **");
			$finish;
		end
	end

	// ------------------------------------------------------------
	// tests
	// ------------------------------------------------------------
	initial begin
		soc_pkg::data_t wval;
		soc_pkg::addr_t bad_addr;
		int unsigned    n;
		int unsigned    extra;
		int unsigned    rsp_mark;
		int unsigned    crd_mark;
		int unsigned    sent_mark;
		int unsigned    sva_errs;

		void'($urandom(75));
		@(posedge ndmreset_n);
		wait_cycles(2);

		// led register
		wval    = {$urandom, $urandom};
		led_val = wval[soc_pkg::LED_W-1:0];
		send_req(1'b1, soc_pkg::GPIO_BASE + soc_pkg::LED_OFS, wval, '0, 1'b0, 1'b0);
		wait_drain();
		err_cnt += check_value("led_o", 64'(led_val), 64'(led));
		send_req(1'b0, soc_pkg::GPIO_BASE + soc_pkg::LED_OFS, '0, 64'(led_val), 1'b0, 1'b1);
		wait_drain();
		end_test("led register");

		// a write at the dip switches must not reach the leds
		dip_val      = 8'($urandom);
		dip_switches = dip_val;
		send_req(1'b0, soc_pkg::GPIO_BASE + soc_pkg::DIP_OFS, '0, 64'(dip_val), 1'b0, 1'b1);
		send_req(1'b1, soc_pkg::GPIO_BASE + soc_pkg::DIP_OFS, {$urandom, $urandom}, '0,
		         1'b0, 1'b0);
		wait_drain();
		err_cnt += check_value("led_o", 64'(led_val), 64'(led));
		end_test("dip switches");

		// unmapped addresses
		bad_addr = 32'h8000_0000 | ($urandom & 32'h0FFF_FFF8);
		send_req(1'b0, bad_addr, '0, '0, 1'b1, 1'b1);
		send_req(1'b1, bad_addr, {$urandom, $urandom}, '0, 1'b1, 1'b1);
		send_req(1'b1, soc_pkg::GPIO_BASE + soc_pkg::GPIO_LEN, '1, '0, 1'b1, 1'b1);
		wait_drain();
		err_cnt += check_value("led_o", 64'(led_val), 64'(led));
		end_test("unmapped address");

		// timer with the compare value at all ones first
		send_req(1'b1, soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, '1, '0, 1'b0, 1'b0);
		wait_drain();
		for (n = 0; n < 10; n++) begin
			wait_cycles(1);
			err_cnt += check_value("timer_irq_o", '0, 64'(timer_irq));
		end
		k_val = $urandom_range(20, 60);
		send_req(1'b1, soc_pkg::CLINT_BASE + soc_pkg::MTIME_OFS, '0, '0, 1'b0, 1'b0);
		send_req(1'b1, soc_pkg::CLINT_BASE + soc_pkg::MTIMECMP_OFS, 64'(k_val), '0, 1'b0, 1'b0);
		wait_drain();
		// mtime counts at half rate, so K cycles cannot reach K
		for (n = 0; n < k_val; n++) begin
			err_cnt += check_value("timer_irq_o", '0, 64'(timer_irq));
			wait_cycles(1);
		end
		while (!timer_irq && n < 2 * k_val + 16) begin
			wait_cycles(1);
			n++;
		end
		assert (timer_irq) else begin
			$display("timer_irq_o did not rise within %0d cycles of the mtimecmp write",
			         2 * k_val + 16);
			err_cnt++;
		end
		send_req(1'b0, soc_pkg::CLINT_BASE + soc_pkg::MTIME_OFS, '0, '0, 1'b0, 1'b0);
		wait_drain();
		assert (last_rdata >= 64'(k_val)) else begin
			$display("** Error at %0t: mtime expected at least %0d, got %0d",
			         $time, k_val, last_rdata);
			err_cnt++;
		end
		end_test("timer");

		// credit flow with response credits held back
		wait_cycles(4);
		hold_rsp_crd = 1'b1;
		rsp_mark     = rsp_cnt;
		crd_mark     = crd_back_cnt;
		sent_mark    = sent_cnt;
		for (n = 0; n < soc_pkg::REQ_FIFO_DEPTH + 2; n++) begin
			send_mixed_read(n % 4);
		end
		wait_cycles(20);
		err_cnt += check_value("rsp_valid_o count", 64'(soc_pkg::RSP_CREDIT_MAX),
		                       64'(rsp_cnt - rsp_mark));
		err_cnt += check_value("req_credit_o count",
		                       64'(soc_pkg::RSP_CREDIT_MAX + soc_pkg::RSP_FIFO_DEPTH),
		                       64'(crd_back_cnt - crd_mark));
		// spend what is left, then the requester has to stall
		extra = soc_pkg::REQ_FIFO_DEPTH + crd_back_cnt - sent_cnt;
		for (n = 0; n < extra; n++) begin
			send_mixed_read((soc_pkg::REQ_FIFO_DEPTH + 2 + n) % 4);
		end
		wait_cycles(10);
		err_cnt += check_value("request credits", '0,
		                       64'(soc_pkg::REQ_FIFO_DEPTH + crd_back_cnt - sent_cnt));
		hold_rsp_crd = 1'b0;
		wait_drain();
		err_cnt += check_value("req_credit_o count", 64'(sent_cnt - sent_mark),
		                       64'(crd_back_cnt - crd_mark));
		end_test("credit flow");

		wait_cycles(4);
		sva_errs = i_soc_top.i_soc_sva.crd_fail_cnt + i_soc_top.i_soc_sva.rsp_fail_cnt +
		           i_soc_top.i_soc_sva.rst_fail_cnt;
		$display("%0d tests ok, %0d tests with errors, %0d assertion failures",
		         tests_ok, tests_bad, sva_errs);
		if (tests_bad == 0 && sva_errs == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hdl/soc_pkg.sv
hdl/credit_fifo.sv
hdl/bus_fabric.sv
hdl/clint_timer.sv
hdl/gpio_regs.sv
hdl/soc_top.sv
bench/tb_clk_gen.sv
bench/soc_sva.sv
bench/tb_soc.sv

// File: run.sh
#!/bin/sh
# compile and run the SoC testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_soc -f files.f

# keep running after an assertion error so the testbench prints its verdict
./obj_dir/Vtb_soc +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0
